//--- verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // pc register value out of reset, so the first sequential fetch is 0x1c000000
    localparam logic [31:0] reset_pc = 32'h1bff_fffc;

    localparam int tlb_entries = 8;
    localparam int tlb_index_w = 3;

    localparam logic [5:0] huge_ps = 6'd22;  // 4 MB page, anything else is 4 KB

    // fetch exception carried along with each instruction
    typedef enum logic [2:0] {
        exc_none = 3'd0,
        exc_adef = 3'd1,  // misaligned pc or user access to high half
        exc_tlbr = 3'd2,  // tlb refill, no entry matched
        exc_pif  = 3'd3,  // page invalid on fetch
        exc_ppi  = 3'd4   // privilege violation
    } fetch_exc_e;

    typedef enum logic [1:0] {
        arb_idle       = 2'd0,
        arb_wait_fetch = 2'd1,
        arb_wait_load  = 2'd2
    } arb_state_e;

endpackage

`default_nettype wire

//--- verilog/tlb_table.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_table (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire                              we,
    input  wire [fetch_pkg::tlb_index_w-1:0] w_index,
    input  wire [19:0]                       w_vppn,     // va[31:12] of the page
    input  wire [5:0]                        w_ps,
    input  wire [19:0]                       w_ppn,
    input  wire [1:0]                        w_plv,
    input  wire                              w_v,
    input  wire [18:0]                       s_vppn,     // va[31:13]
    input  wire                              s_va_bit12,
    output logic                             s_found,
    output logic [19:0]                      s_ppn,
    output logic [5:0]                       s_ps,
    output logic [1:0]                       s_plv,
    output logic                             s_v
);
    import fetch_pkg::*;

    logic [tlb_entries-1:0] e_exist;  // entry has been written since reset
    logic [19:0]            e_vpn [tlb_entries];
    logic [5:0]             e_ps  [tlb_entries];
    logic [19:0]            e_ppn [tlb_entries];
    logic [1:0]             e_plv [tlb_entries];
    logic                   e_v   [tlb_entries];
    logic [tlb_entries-1:0] hit;
    logic [19:0]            s_key;

    assign s_key = {s_vppn, s_va_bit12};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            e_exist <= '0;
        end else if (we) begin
            e_exist[w_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            e_vpn[w_index] <= w_vppn;
            e_ps[w_index]  <= w_ps;
            e_ppn[w_index] <= w_ppn;
            e_plv[w_index] <= w_plv;
            e_v[w_index]   <= w_v;
        end
    end

    // 4 MB pages only compare va[31:22]
    always_comb begin
        for (int i = 0; i < tlb_entries; i++) begin
            hit[i] = e_exist[i] && (e_vpn[i][19:10] == s_key[19:10])
                     && ((e_ps[i] == huge_ps) || (e_vpn[i][9:0] == s_key[9:0]));
        end
    end

    always_comb begin
        s_found = |hit;
        s_ppn   = '0;
        s_ps    = '0;
        s_plv   = '0;
        s_v     = 1'b0;
        for (int i = tlb_entries - 1; i >= 0; i--) begin  // lowest index wins
            if (hit[i]) begin
                s_ppn = e_ppn[i];
                s_ps  = e_ps[i];
                s_plv = e_plv[i];
                s_v   = e_v[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/addr_xlate.sv
`timescale 1ns/1ps
`default_nettype none

module addr_xlate (
    input  wire [31:0]            va,
    input  wire [1:0]             cur_plv,
    input  wire                   direct_mode,
    input  wire                   dmw0_plv0,
    input  wire                   dmw0_plv3,
    input  wire [2:0]             dmw0_vseg,
    input  wire [2:0]             dmw0_pseg,
    input  wire                   dmw1_plv0,
    input  wire                   dmw1_plv3,
    input  wire [2:0]             dmw1_vseg,
    input  wire [2:0]             dmw1_pseg,
    input  wire                   tlb_found,
    input  wire [19:0]            tlb_ppn,
    input  wire [5:0]             tlb_ps,
    input  wire [1:0]             tlb_plv,
    input  wire                   tlb_v,
    output logic [31:0]           pa,
    output fetch_pkg::fetch_exc_e exc,
    output logic [18:0]           tlb_vppn,
    output logic                  tlb_va_bit12
);
    import fetch_pkg::*;

    logic        dmw0_hit;
    logic        dmw1_hit;
    logic        tlb_used;
    logic        adef;
    logic [31:0] tlb_pa;

    assign tlb_vppn     = va[31:13];
    assign tlb_va_bit12 = va[12];

    // window needs the segment and the enable bit of the running level
    assign dmw0_hit = (va[31:29] == dmw0_vseg)
                      && (((cur_plv == 2'd0) && dmw0_plv0) || ((cur_plv == 2'd3) && dmw0_plv3));
    assign dmw1_hit = (va[31:29] == dmw1_vseg)
                      && (((cur_plv == 2'd0) && dmw1_plv0) || ((cur_plv == 2'd3) && dmw1_plv3));

    assign tlb_pa = (tlb_ps == huge_ps) ? {tlb_ppn[19:10], va[21:0]} : {tlb_ppn, va[11:0]};

    assign tlb_used = !direct_mode && !dmw0_hit && !dmw1_hit;

    assign pa = direct_mode ? va :
                dmw0_hit    ? {dmw0_pseg, va[28:0]} :
                dmw1_hit    ? {dmw1_pseg, va[28:0]} :
                              tlb_pa;

    // user code touching the upper half without a window
    assign adef = (|va[1:0]) || (tlb_used && va[31] && (cur_plv == 2'd3));

    always_comb begin
        if (adef) begin
            exc = exc_adef;
        end else if (tlb_used && !tlb_found) begin
            exc = exc_tlbr;
        end else if (tlb_used && !tlb_v) begin
            exc = exc_pif;
        end else if (tlb_used && (cur_plv > tlb_plv)) begin
            exc = exc_ppi;
        end else begin
            exc = exc_none;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire                   clk,
    input  wire                   resetn,
    input  wire                   ds_allowin,
    input  wire                   br_stall,
    input  wire                   br_taken,
    input  wire [31:0]            br_target,
    input  wire                   wb_ex,
    input  wire [31:0]            ex_entry,
    input  wire                   ertn_flush,
    input  wire [31:0]            ertn_entry,
    output logic [31:0]           next_va,
    input  wire [31:0]            next_pa,
    input  wire fetch_pkg::fetch_exc_e xlate_exc,
    output logic                  req,
    output logic [31:0]           addr,
    input  wire                   addr_ok,
    input  wire                   data_ok,
    input  wire [31:0]            rdata,
    output logic                  fs_valid_out,
    output logic [31:0]           fs_pc,
    output logic [31:0]           fs_inst,
    output fetch_pkg::fetch_exc_e fs_exc
);
    import fetch_pkg::*;

    logic        fetch_en;     // low for the first cycle out of reset
    logic        pulse;
    logic [31:0] pulse_target;
    logic        pend_valid;   // redirect seen but not yet accepted
    logic [31:0] pend_target;
    logic        acked;        // request accepted, data_ok not back yet
    logic        discard;      // in-flight response belongs to a cancelled path
    logic        fs_valid;
    logic        buf_valid;
    logic [31:0] inst_buf;
    logic        accept;
    logic        fs_ready_go;
    logic        fs_allowin;

    assign pulse        = wb_ex || ertn_flush || br_taken;
    assign pulse_target = wb_ex ? ex_entry : ertn_flush ? ertn_entry : br_target;

    assign next_va = pulse      ? pulse_target :
                     pend_valid ? pend_target  :
                                  fs_pc + 32'd4;

    assign fs_ready_go  = buf_valid || (data_ok && !discard);
    assign fs_allowin   = !fs_valid || pulse || (fs_ready_go && ds_allowin);
    assign fs_valid_out = fs_valid && fs_ready_go && !pulse;  // a pulse kills the IF slot
    assign fs_inst      = buf_valid ? inst_buf : rdata;

    // br_stall holds fetch unless a flush is redirecting
    assign req    = fetch_en && fs_allowin && !acked && (!br_stall || wb_ex || ertn_flush);
    assign addr   = next_pa;
    assign accept = req && addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pend_valid <= 1'b0;
        end else if (accept) begin
            pend_valid <= 1'b0;  // accepted address already used the target
        end else if (pulse) begin
            pend_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pulse && !accept) begin
            pend_target <= pulse_target;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            acked   <= 1'b0;
            discard <= 1'b0;
        end else begin
            if (accept) begin
                acked <= 1'b1;
            end else if (data_ok) begin
                acked <= 1'b0;
            end
            if (data_ok) begin
                discard <= 1'b0;
            end else if (pulse && acked) begin
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fs_valid  <= 1'b0;
            buf_valid <= 1'b0;
            fs_pc     <= reset_pc;
        end else if (fs_allowin) begin
            fs_valid  <= accept;
            buf_valid <= 1'b0;
            if (accept) begin
                fs_pc <= next_va;
            end
        end else if (data_ok && !discard) begin
            buf_valid <= 1'b1;  // decode stalled, park the word
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fs_exc <= xlate_exc;
        end
        if (!fs_allowin && data_ok && !discard) begin
            inst_buf <= rdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/load_port.sv
`timescale 1ns/1ps
`default_nettype none

module load_port (
    input  wire         clk,
    input  wire         resetn,
    input  wire         load_req,
    input  wire [31:0]  load_addr,
    output logic        req,
    output logic [31:0] addr,
    input  wire         addr_ok,
    input  wire         data_ok,
    input  wire [31:0]  rdata,
    output logic        load_busy,
    output logic        load_done,
    output logic [31:0] load_data
);

    logic        pending;  // request raised, waiting for addr_ok
    logic        waiting;  // accepted, waiting for data_ok
    logic [31:0] addr_r;

    assign req       = pending;
    assign addr      = addr_r;
    assign load_busy = pending || waiting;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending   <= 1'b0;
            waiting   <= 1'b0;
            load_done <= 1'b0;
        end else begin
            load_done <= waiting && data_ok;
            if (pending && addr_ok) begin
                pending <= 1'b0;
                waiting <= 1'b1;
            end else if (waiting && data_ok) begin
                waiting <= 1'b0;
            end else if (load_req && !load_busy) begin
                pending <= 1'b1;  // a request while busy is dropped
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_req && !load_busy) begin
            addr_r <= load_addr;
        end
        if (waiting && data_ok) begin
            load_data <= rdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/sram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module sram_arbiter (
    input  wire         clk,
    input  wire         resetn,
    input  wire         f_req,
    input  wire [31:0]  f_addr,
    output logic        f_addr_ok,
    output logic        f_data_ok,
    output logic [31:0] f_rdata,
    input  wire         l_req,
    input  wire [31:0]  l_addr,
    output logic        l_addr_ok,
    output logic        l_data_ok,
    output logic [31:0] l_rdata,
    output logic        mem_req,
    output logic [31:0] mem_addr,
    input  wire         mem_addr_ok,
    input  wire         mem_data_ok,
    input  wire [31:0]  mem_rdata
);
    import fetch_pkg::*;

    arb_state_e state;
    arb_state_e state_nxt;
    logic       idle;

    assign idle = (state == arb_idle);

    // only one transaction on the bus, so requests go out only from idle
    assign mem_req  = idle && (l_req || f_req);
    assign mem_addr = l_req ? l_addr : f_addr;  // load first

    assign l_addr_ok = idle && l_req && mem_addr_ok;
    assign f_addr_ok = idle && !l_req && f_req && mem_addr_ok;

    assign l_data_ok = (state == arb_wait_load) && mem_data_ok;
    assign f_data_ok = (state == arb_wait_fetch) && mem_data_ok;
    assign l_rdata   = mem_rdata;
    assign f_rdata   = mem_rdata;

    always_comb begin
        state_nxt = state;
        case (state)
            arb_idle: begin
                if (mem_req && mem_addr_ok) begin
                    state_nxt = l_req ? arb_wait_load : arb_wait_fetch;
                end
            end
            arb_wait_fetch, arb_wait_load: begin
                if (mem_data_ok) begin
                    state_nxt = arb_idle;
                end
            end
            default: state_nxt = arb_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= arb_idle;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_subsys_top (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire                              ds_allowin,
    input  wire                              br_stall,
    input  wire                              br_taken,
    input  wire [31:0]                       br_target,
    input  wire                              wb_ex,
    input  wire [31:0]                       ex_entry,
    input  wire                              ertn_flush,
    input  wire [31:0]                       ertn_entry,
    output logic                             fs_valid_out,
    output logic [31:0]                      fs_pc,
    output logic [31:0]                      fs_inst,
    output fetch_pkg::fetch_exc_e            fs_exc,
    input  wire [1:0]                        cur_plv,
    input  wire                              direct_mode,
    input  wire                              dmw0_plv0,
    input  wire                              dmw0_plv3,
    input  wire [2:0]                        dmw0_vseg,
    input  wire [2:0]                        dmw0_pseg,
    input  wire                              dmw1_plv0,
    input  wire                              dmw1_plv3,
    input  wire [2:0]                        dmw1_vseg,
    input  wire [2:0]                        dmw1_pseg,
    input  wire                              tlb_we,
    input  wire [fetch_pkg::tlb_index_w-1:0] tlb_w_index,
    input  wire [19:0]                       tlb_w_vppn,
    input  wire [5:0]                        tlb_w_ps,
    input  wire [19:0]                       tlb_w_ppn,
    input  wire [1:0]                        tlb_w_plv,
    input  wire                              tlb_w_v,
    input  wire                              load_req,
    input  wire [31:0]                       load_addr,
    output logic                             load_busy,
    output logic                             load_done,
    output logic [31:0]                      load_data,
    output logic                             mem_req,
    output logic [31:0]                      mem_addr,
    input  wire                              mem_addr_ok,
    input  wire                              mem_data_ok,
    input  wire [31:0]                       mem_rdata
);
    import fetch_pkg::*;

    logic [31:0] next_va;
    logic [31:0] next_pa;
    fetch_exc_e  xlate_exc;
    logic [18:0] s_vppn;
    logic        s_va_bit12;
    logic        s_found;
    logic [19:0] s_ppn;
    logic [5:0]  s_ps;
    logic [1:0]  s_plv;
    logic        s_v;
    logic        f_req, f_addr_ok, f_data_ok;
    logic [31:0] f_addr, f_rdata;
    logic        l_req, l_addr_ok, l_data_ok;
    logic [31:0] l_addr, l_rdata;

    fetch_stage fetch_stage_i (
        .clk, .resetn, .ds_allowin, .br_stall,
        .br_taken, .br_target, .wb_ex, .ex_entry, .ertn_flush, .ertn_entry,
        .next_va, .next_pa, .xlate_exc,
        .req(f_req), .addr(f_addr), .addr_ok(f_addr_ok), .data_ok(f_data_ok), .rdata(f_rdata),
        .fs_valid_out, .fs_pc, .fs_inst, .fs_exc
    );

    // translation sees the pc being chosen this cycle
    addr_xlate addr_xlate_i (
        .va(next_va), .cur_plv, .direct_mode,
        .dmw0_plv0, .dmw0_plv3, .dmw0_vseg, .dmw0_pseg,
        .dmw1_plv0, .dmw1_plv3, .dmw1_vseg, .dmw1_pseg,
        .tlb_found(s_found), .tlb_ppn(s_ppn), .tlb_ps(s_ps), .tlb_plv(s_plv), .tlb_v(s_v),
        .pa(next_pa), .exc(xlate_exc), .tlb_vppn(s_vppn), .tlb_va_bit12(s_va_bit12)
    );

    tlb_table tlb_table_i (
        .clk, .resetn,
        .we(tlb_we), .w_index(tlb_w_index), .w_vppn(tlb_w_vppn), .w_ps(tlb_w_ps),
        .w_ppn(tlb_w_ppn), .w_plv(tlb_w_plv), .w_v(tlb_w_v),
        .s_vppn, .s_va_bit12, .s_found, .s_ppn, .s_ps, .s_plv, .s_v
    );

    load_port load_port_i (
        .clk, .resetn, .load_req, .load_addr,
        .req(l_req), .addr(l_addr), .addr_ok(l_addr_ok), .data_ok(l_data_ok), .rdata(l_rdata),
        .load_busy, .load_done, .load_data
    );

    sram_arbiter sram_arbiter_i (
        .clk, .resetn,
        .f_req, .f_addr, .f_addr_ok, .f_data_ok, .f_rdata,
        .l_req, .l_addr, .l_addr_ok, .l_data_ok, .l_rdata,
        .mem_req, .mem_addr, .mem_addr_ok, .mem_data_ok, .mem_rdata
    );

endmodule

`default_nettype wire

//--- verif/inst_sram_model.sv
`timescale 1ns/1ps
`default_nettype none

module inst_sram_model (
    input  wire         clk,
    input  wire         resetn,
    input  wire         mem_req,
    input  wire [31:0]  mem_addr,
    output logic        mem_addr_ok,
    output logic        mem_data_ok,
    output logic [31:0] mem_rdata
);

    localparam logic [31:0] word_key = 32'ha5a5_a5a5;

    logic        busy = 1'b0;       // one transaction outstanding
    logic [1:0]  lat = 2'd0;        // cycles left before data_ok
    logic [1:0]  stall = 2'd0;      // addr_ok stall cycles left
    logic [31:0] addr_q = 32'd0;

    assign mem_addr_ok = !busy && mem_req && (stall == 2'd0);
    assign mem_data_ok = busy && (lat == 2'd0);
    assign mem_rdata   = addr_q ^ word_key;  // content is a function of the address

    always @(posedge clk) begin
        if (!resetn) begin
            busy  <= 1'b0;
            lat   <= 2'd0;
            stall <= 2'($urandom_range(0, 2));
        end else if (!busy) begin
            if (mem_addr_ok) begin
                busy   <= 1'b1;
                addr_q <= mem_addr;
                lat    <= 2'($urandom_range(0, 2));  // 1 to 3 cycles to data_ok
                stall  <= 2'($urandom_range(0, 2));
            end else if (mem_req && stall != 2'd0) begin
                stall <= stall - 2'd1;
            end
        end else if (lat == 2'd0) begin
            busy <= 1'b0;
        end else begin
            lat <= lat - 2'd1;
        end
    end

endmodule

`default_nettype wire

//--- verif/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    localparam logic [31:0] word_key = 32'ha5a5_a5a5;
    localparam int wait_limit = 2000;

    logic clk = 1'b0;
    logic resetn, ds_allowin, br_stall, br_taken, wb_ex, ertn_flush;
    logic [31:0] br_target, ex_entry, ertn_entry, load_addr;
    logic [1:0] cur_plv;
    logic direct_mode, dmw0_plv0, dmw0_plv3, dmw1_plv0, dmw1_plv3, load_req;
    logic [2:0] dmw0_vseg, dmw0_pseg, dmw1_vseg, dmw1_pseg;
    logic tlb_we, tlb_w_v;
    logic [tlb_index_w-1:0] tlb_w_index;
    logic [19:0] tlb_w_vppn, tlb_w_ppn;
    logic [5:0] tlb_w_ps;
    logic [1:0] tlb_w_plv;
    logic fs_valid_out, load_busy, load_done, mem_req, mem_addr_ok, mem_data_ok;
    logic [31:0] fs_pc, fs_inst, load_data, mem_addr, mem_rdata;
    fetch_exc_e fs_exc;

    // reference copy of the tlb contents
    bit          t_valid [tlb_entries];
    logic [19:0] t_vpn [tlb_entries];
    logic [5:0]  t_ps [tlb_entries];
    logic [19:0] t_ppn [tlb_entries];
    logic [1:0]  t_plv [tlb_entries];
    logic        t_v [tlb_entries];

    int errors = 0, checks = 0, xfer_cnt = 0, load_cnt = 0;
    int tests_run = 0, tests_failed = 0, test_err0 = 0;
    logic [31:0] exp_pc;
    bit first_seen = 1'b0;
    fetch_exc_e first_exc;
    logic [31:0] load_q [$];
    bit load_open = 1'b0;  // load issued and its load_done not seen yet
    bit bp_en = 1'b0;

    fetch_subsys_top fetch_subsys_top_i (.*);
    inst_sram_model sram_model_i (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        ds_allowin <= bp_en ? (($urandom % 4) != 0) : 1'b1;  // random back-pressure
    end

    // returns {exception, physical address} for a fetch of va
    function automatic logic [34:0] ref_fetch(input logic [31:0] va);
        logic d0, d1, used;
        logic [31:0] pa;
        fetch_exc_e e;
        int hit;
        d0 = (va[31:29] == dmw0_vseg)
             && ((cur_plv == 2'd0 && dmw0_plv0) || (cur_plv == 2'd3 && dmw0_plv3));
        d1 = (va[31:29] == dmw1_vseg)
             && ((cur_plv == 2'd0 && dmw1_plv0) || (cur_plv == 2'd3 && dmw1_plv3));
        used = !direct_mode && !d0 && !d1;
        hit = -1;
        for (int i = 0; i < tlb_entries; i++) begin
            if (hit < 0 && t_valid[i] && t_vpn[i][19:10] == va[31:22]
                && (t_ps[i] == huge_ps || t_vpn[i][9:0] == va[21:12]))
                hit = i;
        end
        if (direct_mode) pa = va;
        else if (d0) pa = {dmw0_pseg, va[28:0]};
        else if (d1) pa = {dmw1_pseg, va[28:0]};
        else if (hit < 0) pa = {20'd0, va[11:0]};
        else if (t_ps[hit] == huge_ps) pa = {t_ppn[hit][19:10], va[21:0]};
        else pa = {t_ppn[hit], va[11:0]};
        if (va[1:0] != 2'd0 || (used && va[31] && cur_plv == 2'd3)) e = exc_adef;
        else if (used && hit < 0) e = exc_tlbr;
        else if (used && !t_v[hit]) e = exc_pif;
        else if (used && cur_plv > t_plv[hit]) e = exc_ppi;
        else e = exc_none;
        return {e, pa};
    endfunction

    always @(posedge clk) begin : compare_proc
        logic [34:0] r;
        logic [31:0] a;
        logic        busy_exp;
        if (!resetn) begin
            exp_pc = 32'h1c00_0000;
        end else if (wb_ex || ertn_flush || br_taken) begin
            assert (!(fs_valid_out && ds_allowin)) else begin
                $display("instruction reached decode in the cycle of a redirect");
                errors++;
            end
            exp_pc = wb_ex ? ex_entry : ertn_flush ? ertn_entry : br_target;
            first_seen = 1'b0;
        end else if (fs_valid_out && ds_allowin) begin
            r = ref_fetch(exp_pc);
            checks++;
            assert (fs_pc == exp_pc) else begin
                $display("Error: fs_pc got %h expected %h", fs_pc, exp_pc);
                errors++;
            end
            assert (fs_exc == fetch_exc_e'(r[34:32])) else begin
                $display("Error: fs_exc got %h expected %h", fs_exc, r[34:32]);
                errors++;
            end
            if (r[34:32] == exc_none) begin
                assert (fs_inst == (r[31:0] ^ word_key)) else begin
                    $display("Error: fs_inst got %h expected %h", fs_inst, r[31:0] ^ word_key);
                    errors++;
                end
            end
            if (!first_seen) begin
                first_seen = 1'b1;
                first_exc = fs_exc;
            end
            exp_pc = exp_pc + 32'd4;
            xfer_cnt++;
        end
        if (resetn) begin
            busy_exp = load_open && !load_done;  // busy drops as load_done rises
            assert (load_busy == busy_exp) else begin
                $display("Error: load_busy got %h expected %h", load_busy, busy_exp);
                errors++;
            end
        end
        if (resetn && load_done) begin
            assert (load_q.size() > 0) else begin
                $display("load_done arrived with no load outstanding");
                errors++;
            end
            if (load_q.size() > 0) begin
                a = load_q.pop_front();
                checks++;
                assert (load_data == (a ^ word_key)) else begin
                    $display("Error: load_data got %h expected %h", load_data, a ^ word_key);
                    errors++;
                end
            end
            load_open = 1'b0;
            load_cnt++;
        end
        if (resetn && load_req) begin
            load_open = 1'b1;
        end
    end

    task automatic wait_xfers(input int n);
        int target;
        int t;
        target = xfer_cnt + n;
        t = 0;
        while (xfer_cnt < target && t < wait_limit) begin
            @(posedge clk);
            t++;
        end
        if (xfer_cnt < target) begin
            $display("timeout: instructions stopped reaching decode");
            errors++;
        end
    endtask

    // caller is at a rising edge
    task automatic fire(input bit b, input bit e, input bit r, input logic [31:0] tb_t,
                        input logic [31:0] te, input logic [31:0] tr);
        br_taken <= b;
        wb_ex <= e;
        ertn_flush <= r;
        br_target <= tb_t;
        ex_entry <= te;
        ertn_entry <= tr;
        @(posedge clk);
        br_taken <= 1'b0;
        wb_ex <= 1'b0;
        ertn_flush <= 1'b0;
    endtask

    task automatic jump(input logic [31:0] target, input fetch_exc_e want);
        fire(1'b1, 1'b0, 1'b0, target, 32'd0, 32'd0);
        wait_xfers(3);
        assert (first_seen && first_exc == want) else begin
            $display("Error: fs_exc got %h expected %h at pc %h", first_exc, want, target);
            errors++;
        end
        @(posedge clk);
    endtask

    task automatic write_tlb(input int idx, input logic [19:0] vppn, input logic [5:0] ps,
                             input logic [19:0] ppn, input logic [1:0] plv, input logic v);
        @(posedge clk);
        tlb_we <= 1'b1;
        tlb_w_index <= tlb_index_w'(idx);
        tlb_w_vppn <= vppn;
        tlb_w_ps <= ps;
        tlb_w_ppn <= ppn;
        tlb_w_plv <= plv;
        tlb_w_v <= v;
        t_valid[idx] = 1'b1;
        t_vpn[idx] = vppn;
        t_ps[idx] = ps;
        t_ppn[idx] = ppn;
        t_plv[idx] = plv;
        t_v[idx] = v;
        @(posedge clk);
        tlb_we <= 1'b0;
    endtask

    task automatic load_one();
        logic [31:0] a;
        int target;
        int t;
        a = 32'h1c00_0000 | ($urandom & 32'h000f_fffc);
        @(posedge clk);
        load_req <= 1'b1;
        load_addr <= a;
        load_q.push_back(a);
        @(posedge clk);
        load_req <= 1'b0;
        target = load_cnt + 1;
        t = 0;
        while (load_cnt < target && t < wait_limit) begin
            @(posedge clk);
            t++;
        end
        if (load_cnt < target) begin
            $display("timeout: load at %h never returned", a);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_err0) tests_failed++;
        $display("test %s %s", name, (errors == test_err0) ? "passed" : "failed");
        test_err0 = errors;
    endtask

    initial begin
        logic [2:0] sel;
        void'($urandom(53455));
        resetn = 1'b0;
        ds_allowin = 1'b1;
        br_stall = 1'b0;
        {br_taken, wb_ex, ertn_flush} = 3'b000;
        {br_target, ex_entry, ertn_entry} = '0;
        cur_plv = 2'd0;
        direct_mode = 1'b1;
        {dmw0_plv0, dmw0_plv3, dmw0_vseg, dmw0_pseg} = {1'b1, 1'b0, 3'h5, 3'h0};
        {dmw1_plv0, dmw1_plv3, dmw1_vseg, dmw1_pseg} = {1'b0, 1'b0, 3'h4, 3'h1};
        {tlb_we, tlb_w_index, tlb_w_vppn, tlb_w_ps, tlb_w_ppn, tlb_w_plv, tlb_w_v} = '0;
        load_req = 1'b0;
        load_addr = '0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;

        bp_en <= 1'b1;
        wait_xfers(40);
        end_test("sequential");

        repeat (12) begin
            repeat ($urandom_range(0, 6)) @(posedge clk);
            @(posedge clk);
            sel = 3'($urandom_range(1, 7));  // sometimes all pulses together
            fire(sel[0], sel[1], sel[2], 32'h1c01_0000 | ($urandom & 32'hffc),
                 32'h1c02_0000 | ($urandom & 32'hffc), 32'h1c03_0000 | ($urandom & 32'hffc));
            wait_xfers(2);
        end
        end_test("redirect");

        @(posedge clk);
        direct_mode <= 1'b0;  // config switches with the redirect
        jump(32'ha000_1000, exc_none);
        jump(32'ha000_1002, exc_adef);
        end_test("dmw");

        write_tlb(0, 20'h00010, 6'd12, 20'h1c008, 2'd0, 1'b1);
        write_tlb(1, 20'h00400, huge_ps, 20'h1c400, 2'd3, 1'b1);
        write_tlb(2, 20'h00020, 6'd12, 20'h1c009, 2'd0, 1'b0);
        @(posedge clk);
        jump(32'h0001_0040, exc_none);
        jump(32'h0040_0100, exc_none);
        jump(32'h0002_0000, exc_pif);
        jump(32'h0003_0000, exc_tlbr);
        cur_plv <= 2'd3;
        jump(32'h0001_0000, exc_ppi);
        cur_plv <= 2'd0;
        jump(32'h0040_0200, exc_none);
        end_test("tlb");

        direct_mode <= 1'b1;
        jump(32'h1c00_0100, exc_none);
        repeat (10) load_one();
        wait_xfers(4);
        end_test("loads");

        bp_en <= 1'b0;
        repeat (4) @(posedge clk);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
verilog/fetch_pkg.sv
verilog/tlb_table.sv
verilog/addr_xlate.sv
verilog/fetch_stage.sv
verilog/load_port.sv
verilog/sram_arbiter.sv
verilog/fetch_subsys_top.sv
verif/inst_sram_model.sv
verif/fetch_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
TOP       = fetch_tb
FILELIST  = compile.f
BUILD     = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD)
